//--- rtl/affine_pkg.sv
// --------------------------------------------------
// Shared sizes and types for the affine stage
// --------------------------------------------------

`default_nettype none

package affine_pkg;

  // Stream shape
  localparam int channels = 2;
  localparam int parallel_samples = 2;
  localparam int sample_width = 16;               // Signed 0Q16 samples
  localparam int channel_index_width = (channels > 1) ? $clog2(channels) : 1;

  // Coefficient formats
  localparam int scale_width = 18;                // 2Q16
  localparam int scale_int_bits = 2;
  localparam int scale_frac_bits = scale_width - scale_int_bits;
  localparam int offset_width = 14;               // 0Q14

  // Offset moves into the 2Q32 product scale
  localparam int offset_shift = sample_width + scale_frac_bits - offset_width;

  // Arithmetic widths
  localparam int product_width = sample_width + scale_width;  // 34
  localparam int sum_width = product_width + 1;               // 35, one guard bit

  // Latency, input register through output register
  localparam int pipe_latency = 4;
  localparam int datapath_stages = pipe_latency - 1;

  // Flat port widths
  localparam int group_width = parallel_samples * sample_width;
  localparam int flat_width = channels * group_width;

  typedef logic signed [sample_width-1:0] sample_t;
  typedef logic signed [product_width-1:0] product_t;
  typedef logic signed [sum_width-1:0] sum_t;
  typedef logic signed [scale_width-1:0] scale_t;
  typedef logic signed [offset_width-1:0] offset_t;

  typedef sample_t [parallel_samples-1:0] sample_group_t;
  typedef sum_t [parallel_samples-1:0] sum_group_t;
  typedef scale_t [channels-1:0] scale_array_t;
  typedef offset_t [channels-1:0] offset_array_t;

  localparam scale_t scale_unity = scale_t'(1) <<< scale_frac_bits;  // 1.0
  localparam sample_t sample_max = {1'b0, {(sample_width-1){1'b1}}};
  localparam sample_t sample_min = {1'b1, {(sample_width-1){1'b0}}};

endpackage

`default_nettype wire

//--- rtl/coefficient_bank.sv
// --------------------------------------------------
// Coefficient bank, pending and active scale/offset
// Apply pulse switches every channel in one cycle
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module coefficient_bank (
  input  logic                                      data_clk,
  input  logic                                      data_reset,
  input  logic                                      config_write,
  input  logic [affine_pkg::channel_index_width-1:0] config_channel,
  input  logic signed [affine_pkg::scale_width-1:0] config_scale,
  input  logic signed [affine_pkg::offset_width-1:0] config_offset,
  input  logic                                      config_apply,
  output affine_pkg::scale_array_t                  active_scale,
  output affine_pkg::offset_array_t                 active_offset
);

  import affine_pkg::*;

  scale_array_t  pending_scale;
  offset_array_t pending_offset;
  scale_array_t  next_scale;     // Pending bank including this cycle's write
  offset_array_t next_offset;

  // A write and an apply on the same edge carry the write through
  always_comb begin
    next_scale = pending_scale;
    next_offset = pending_offset;
    if (config_write) begin
      for (int ch = 0; ch < channels; ch++) begin
        if (config_channel == ch) begin
          next_scale[ch] = config_scale;
          next_offset[ch] = config_offset;
        end
      end
    end
  end

  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      for (int ch = 0; ch < channels; ch++) begin
        pending_scale[ch] <= scale_unity;
        pending_offset[ch] <= '0;
      end
    end else begin
      pending_scale <= next_scale;
      pending_offset <= next_offset;
    end
  end

  // Whole bank moves at once
  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      for (int ch = 0; ch < channels; ch++) begin
        active_scale[ch] <= scale_unity;   // Pass-through after reset
        active_offset[ch] <= '0;
      end
    end else if (config_apply) begin
      active_scale <= next_scale;
      active_offset <= next_offset;
    end
  end

  // A write with unknown fields would corrupt the pending bank
  assert property (@(posedge data_clk) disable iff (data_reset)
    config_write |-> !$isunknown({config_channel, config_scale, config_offset}))
    else $error("config_write with unknown channel, scale or offset");

endmodule

`default_nettype wire

//--- rtl/affine_datapath.sv
// --------------------------------------------------
// Affine datapath, x*scale + offset per sample
// Input, product and sum stages with valid delay
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module affine_datapath (
  input  logic                            data_clk,
  input  logic                            data_reset,
  input  affine_pkg::sample_group_t       in_data [affine_pkg::channels],
  input  logic [affine_pkg::channels-1:0] in_valid,
  input  affine_pkg::scale_array_t        active_scale,
  input  affine_pkg::offset_array_t       active_offset,
  output affine_pkg::sum_group_t          sum_data [affine_pkg::channels],
  output logic [affine_pkg::channels-1:0] sum_valid
);

  import affine_pkg::*;

  sample_group_t input_reg [channels];                     // 0Q16
  product_t      product_reg [channels][parallel_samples]; // 2Q32
  sum_t          offset_aligned [channels];                // 0Q14 moved to 2Q32

  // One shift line per channel, oldest bit lines up with the sum stage
  logic [datapath_stages-1:0] valid_line [channels];

  // Sign extend, then shift into the product's binary point
  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      offset_aligned[ch] = sum_t'($signed(active_offset[ch])) <<< offset_shift;
    end
  end

  always_ff @(posedge data_clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      input_reg[ch] <= in_data[ch];
    end
  end

  // 16x18 signed, full 34-bit result
  always_ff @(posedge data_clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        product_reg[ch][s] <= $signed(input_reg[ch][s]) * $signed(active_scale[ch]);
      end
    end
  end

  // Guard bit keeps the sum from wrapping
  always_ff @(posedge data_clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        sum_data[ch][s] <= sum_t'(product_reg[ch][s]) + offset_aligned[ch];
      end
    end
  end

  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      for (int ch = 0; ch < channels; ch++) begin
        valid_line[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        valid_line[ch] <= {valid_line[ch][datapath_stages-2:0], in_valid[ch]};
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      sum_valid[ch] = valid_line[ch][datapath_stages-1];
    end
  end

  // An X on in_valid would otherwise surface three cycles later
  assert property (@(posedge data_clk) disable iff (data_reset)
    !$isunknown(sum_valid))
    else $error("sum_valid is unknown");

endmodule

`default_nettype wire

//--- rtl/output_saturator.sv
// --------------------------------------------------
// Output saturator, floors each sum to 16 bits
// and clamps instead of wrapping
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module output_saturator (
  input  logic                              data_clk,
  input  logic                              data_reset,
  input  affine_pkg::sum_group_t            sum_data [affine_pkg::channels],
  input  logic [affine_pkg::channels-1:0]   sum_valid,
  output logic [affine_pkg::flat_width-1:0] out_data,
  output logic [affine_pkg::channels-1:0]   out_valid
);

  import affine_pkg::*;

  // Dropping the low fraction bits gives the floor
  function automatic sample_t clamp_sample(input sum_t value);
    logic [sum_width-scale_frac_bits-sample_width:0] high_bits;
    high_bits = value[sum_width-1:scale_frac_bits+sample_width-1];
    if ((&high_bits) || !(|high_bits)) begin
      return value[scale_frac_bits +: sample_width];  // High bits are a plain sign extension
    end else if (value[sum_width-1]) begin
      return sample_min;
    end else begin
      return sample_max;
    end
  endfunction

  sample_t clamped [channels][parallel_samples];

  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        clamped[ch][s] = clamp_sample(sum_data[ch][s]);
      end
    end
  end

  // Channel-major packing as in in_data
  always_ff @(posedge data_clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        out_data[(ch*parallel_samples + s)*sample_width +: sample_width] <= clamped[ch][s];
      end
    end
  end

  always_ff @(posedge data_clk) begin
    if (data_reset) begin
      out_valid <= '0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  // Clamping keeps the sign of the sum
  for (genvar ch = 0; ch < channels; ch++) begin : g_check_channel
    for (genvar s = 0; s < parallel_samples; s++) begin : g_check_sample
      assert property (@(posedge data_clk) disable iff (data_reset)
        out_valid[ch] |->
          (out_data[(ch*parallel_samples + s)*sample_width + sample_width - 1]
            == $past(sum_data[ch][s][sum_width-1])))
        else $error("Output sample %0d of channel %0d has wrapped", s, ch);
    end
  end

endmodule

`default_nettype wire

//--- rtl/affine_scaler_top.sv
// --------------------------------------------------
// Multichannel affine scaler, top level
// Coefficient bank, datapath and saturator
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module affine_scaler_top (
  input  logic                                       data_clk,
  input  logic                                       data_reset,

  // Sample stream, channel-major
  input  logic [affine_pkg::flat_width-1:0]          in_data,
  input  logic [affine_pkg::channels-1:0]            in_valid,

  // Coefficient loading
  input  logic                                       config_write,
  input  logic [affine_pkg::channel_index_width-1:0] config_channel,
  input  logic signed [affine_pkg::scale_width-1:0]  config_scale,   // 2Q16
  input  logic signed [affine_pkg::offset_width-1:0] config_offset,  // 0Q14
  input  logic                                       config_apply,

  output logic [affine_pkg::flat_width-1:0]          out_data,
  output logic [affine_pkg::channels-1:0]            out_valid
);

  import affine_pkg::*;

  sample_group_t in_groups [channels];
  scale_array_t  active_scale;
  offset_array_t active_offset;
  sum_group_t    sum_data [channels];
  logic [channels-1:0] sum_valid;

  for (genvar ch = 0; ch < channels; ch++) begin : g_unpack
    assign in_groups[ch] = in_data[ch*group_width +: group_width];
  end

  coefficient_bank i_coefficient_bank (
    .data_clk       (data_clk),
    .data_reset     (data_reset),
    .config_write   (config_write),
    .config_channel (config_channel),
    .config_scale   (config_scale),
    .config_offset  (config_offset),
    .config_apply   (config_apply),
    .active_scale   (active_scale),
    .active_offset  (active_offset)
  );

  // Three cycles, input through sum
  affine_datapath i_affine_datapath (
    .data_clk      (data_clk),
    .data_reset    (data_reset),
    .in_data       (in_groups),
    .in_valid      (in_valid),
    .active_scale  (active_scale),
    .active_offset (active_offset),
    .sum_data      (sum_data),
    .sum_valid     (sum_valid)
  );

  // Last stage, one cycle
  output_saturator i_output_saturator (
    .data_clk   (data_clk),
    .data_reset (data_reset),
    .sum_data   (sum_data),
    .sum_valid  (sum_valid),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

endmodule

`default_nettype wire

//--- verification/affine_checker.sv
// --------------------------------------------------
// Scoreboard for the affine scaler, reference model,
// expected-value queues and output comparison
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module affine_checker (
  input  logic                                       data_clk,
  input  logic                                       data_reset,
  input  logic [affine_pkg::flat_width-1:0]          in_data,
  input  logic [affine_pkg::channels-1:0]            in_valid,
  input  logic                                       config_write,
  input  logic [affine_pkg::channel_index_width-1:0] config_channel,
  input  logic signed [affine_pkg::scale_width-1:0]  config_scale,
  input  logic signed [affine_pkg::offset_width-1:0] config_offset,
  input  logic                                       config_apply,
  input  logic [affine_pkg::flat_width-1:0]          out_data,
  input  logic [affine_pkg::channels-1:0]            out_valid,
  output int                                         check_count,
  output int                                         error_count,
  output int                                         pending_count
);

  import affine_pkg::*;

  localparam int expected_latency = 4;  // Input edge to output edge

  logic signed [scale_width-1:0]  pending_scale_m [channels];
  logic signed [offset_width-1:0] pending_offset_m [channels];
  logic signed [scale_width-1:0]  active_scale_m [channels];
  logic signed [offset_width-1:0] active_offset_m [channels];

  logic [group_width-1:0] expected_q [channels][$];    // One entry per valid group
  int                     push_cycle_q [channels][$];  // Edge index the group was taken on
  int                     cycle_count;

  // sum = x*s + o*2^18, floored by 2^16 and clamped to 16 bits
  function automatic int expected_sample(input int x, input longint s, input longint o);
    longint sum;
    longint floored;
    sum = longint'(x) * s + o * 64'sd262144;
    floored = sum >>> 16;  // Arithmetic shift rounds toward minus infinity
    if (floored > 64'sd32767) begin
      return 32767;
    end else if (floored < -64'sd32768) begin
      return -32768;
    end else begin
      return int'(floored);
    end
  endfunction

  always @(posedge data_clk) begin : model
    logic [group_width-1:0] group;
    int got;
    int want;
    int latency;
    if (data_reset) begin
      for (int ch = 0; ch < channels; ch++) begin
        pending_scale_m[ch] = 18'sd65536;  // Unity
        pending_offset_m[ch] = '0;
        active_scale_m[ch] = 18'sd65536;
        active_offset_m[ch] = '0;
        expected_q[ch].delete();
        push_cycle_q[ch].delete();
      end
      cycle_count = 0;
      check_count = 0;
      error_count = 0;
      pending_count = 0;
    end else begin
      cycle_count++;
      // Outputs seen here were registered on the previous edge
      for (int ch = 0; ch < channels; ch++) begin
        if (out_valid[ch]) begin
          if (expected_q[ch].size() == 0) begin
            $display("Error at %0t ns: out_valid on channel %0d with no group outstanding",
                     $time, ch);
            error_count++;
          end else begin
            group = expected_q[ch].pop_front();
            latency = cycle_count - push_cycle_q[ch].pop_front();
            if (latency != expected_latency) begin
              $display("Error at %0t ns: channel %0d output came %0d cycles after its input",
                       $time, ch, latency);
              error_count++;
            end
            for (int s = 0; s < parallel_samples; s++) begin
              got = int'($signed(out_data[(ch*parallel_samples + s)*sample_width +: sample_width]));
              want = int'($signed(group[s*sample_width +: sample_width]));
              check_count++;
              if (got != want) begin
                $display("Mismatch at %0t ns: channel %0d sample %0d is %0d, expected %0d",
                         $time, ch, s, got, want);
                error_count++;
              end
            end
          end
        end
      end
      if (config_write) begin
        pending_scale_m[config_channel] = config_scale;
        pending_offset_m[config_channel] = config_offset;
      end
      if (config_apply) begin  // Write on the same edge is carried along
        active_scale_m = pending_scale_m;
        active_offset_m = pending_offset_m;
      end
      for (int ch = 0; ch < channels; ch++) begin
        if (in_valid[ch]) begin
          for (int s = 0; s < parallel_samples; s++) begin
            group[s*sample_width +: sample_width] = sample_width'(expected_sample(
              int'($signed(in_data[(ch*parallel_samples + s)*sample_width +: sample_width])),
              longint'(active_scale_m[ch]), longint'(active_offset_m[ch])));
          end
          expected_q[ch].push_back(group);
          push_cycle_q[ch].push_back(cycle_count);
        end
      end
      pending_count = 0;
      for (int ch = 0; ch < channels; ch++) begin
        pending_count += expected_q[ch].size();
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/affine_tb.sv
// --------------------------------------------------
// Testbench for the affine scaler, table-driven
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module affine_tb;

  import affine_pkg::*;

  typedef enum logic [1:0] {kind_write, kind_apply, kind_group, kind_idle} entry_kind_t;

  typedef struct {
    entry_kind_t                    kind;
    int                             test;
    int                             channel;
    logic signed [scale_width-1:0]  scale;
    logic signed [offset_width-1:0] offset;
    logic [flat_width-1:0]          data;
    logic [channels-1:0]            valid;
    int                             cycles;
  } entry_t;

  localparam int num_tests = 5;
  localparam int drain_timeout = 50;  // Cycles

  logic                           data_clk;
  logic                           data_reset;
  logic [flat_width-1:0]          in_data;
  logic [channels-1:0]            in_valid;
  logic                           config_write;
  logic [channel_index_width-1:0] config_channel;
  logic signed [scale_width-1:0]  config_scale;
  logic signed [offset_width-1:0] config_offset;
  logic                           config_apply;
  logic [flat_width-1:0]          out_data;
  logic [channels-1:0]            out_valid;
  int                             check_count;
  int                             error_count;
  int                             pending_count;

  entry_t stimulus [$];
  string  test_names [num_tests] = '{"reset pass-through", "per-channel coefficients",
                                     "saturation", "atomic apply", "random stream"};

  affine_scaler_top i_dut (
    .data_clk       (data_clk),
    .data_reset     (data_reset),
    .in_data        (in_data),
    .in_valid       (in_valid),
    .config_write   (config_write),
    .config_channel (config_channel),
    .config_scale   (config_scale),
    .config_offset  (config_offset),
    .config_apply   (config_apply),
    .out_data       (out_data),
    .out_valid      (out_valid)
  );

  affine_checker i_checker (
    .data_clk       (data_clk),
    .data_reset     (data_reset),
    .in_data        (in_data),
    .in_valid       (in_valid),
    .config_write   (config_write),
    .config_channel (config_channel),
    .config_scale   (config_scale),
    .config_offset  (config_offset),
    .config_apply   (config_apply),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .check_count    (check_count),
    .error_count    (error_count),
    .pending_count  (pending_count)
  );

  initial begin
    data_clk = 1'b0;
    forever #20 data_clk = ~data_clk;  // 40 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Channel-major, channel 0 sample 0 in the low bits
  function automatic logic [flat_width-1:0] pack_group(input int c0s0, input int c0s1,
                                                       input int c1s0, input int c1s1);
    return {16'(c1s1), 16'(c1s0), 16'(c0s1), 16'(c0s0)};
  endfunction

  function automatic void push_entry(input entry_kind_t kind, input int test, input int channel,
                                     input int scale, input int offset,
                                     input logic [flat_width-1:0] data,
                                     input logic [channels-1:0] valid, input int cycles);
    entry_t e;
    e.kind = kind;
    e.test = test;
    e.channel = channel;
    e.scale = scale_width'(scale);
    e.offset = offset_width'(offset);
    e.data = data;
    e.valid = valid;
    e.cycles = cycles;
    stimulus.push_back(e);
  endfunction

  function automatic void add_write(input int test, input int channel, input int scale,
                                    input int offset);
    push_entry(kind_write, test, channel, scale, offset, '0, '0, 1);
  endfunction

  function automatic void add_apply(input int test);
    push_entry(kind_apply, test, 0, 0, 0, '0, '0, 1);
  endfunction

  function automatic void add_group(input int test, input logic [channels-1:0] valid,
                                    input logic [flat_width-1:0] data);
    push_entry(kind_group, test, 0, 0, 0, data, valid, 1);
  endfunction

  function automatic void add_idle(input int test, input int cycles);
    push_entry(kind_idle, test, 0, 0, 0, '0, '0, cycles);
  endfunction

  // Scale is 2Q16 (65536 = 1.0), offset adds offset*4 output LSBs
  function automatic void build_stimulus();
    logic [31:0]           state;
    logic [flat_width-1:0] data;
    logic [channels-1:0]   valid;
    state = 32'h782f_6f87;
    add_group(0, 2'b11, pack_group(0, 1, -1, 32767));
    add_group(0, 2'b11, pack_group(-32768, 1234, -4321, 16384));
    add_group(0, 2'b01, pack_group(500, -500, 7, 7));
    add_group(0, 2'b10, pack_group(9, 9, -12345, 23456));
    add_group(0, 2'b11, pack_group(100, 200, 300, 400));
    add_idle(1, 6);
    add_write(1, 0, 32768, 2048);      // 0.5, +8192
    add_write(1, 1, -98304, -1000);    // -1.5, -4000
    add_apply(1);
    add_idle(1, 2);
    add_group(1, 2'b11, pack_group(1000, -1000, 1000, -1000));
    add_group(1, 2'b11, pack_group(-7, 32767, 3, -20000));
    add_group(1, 2'b11, pack_group(-32768, 12345, 21000, 0));
    add_idle(2, 6);
    add_write(2, 0, 131071, 8191);     // Nearly 2.0, largest offset
    add_write(2, 1, 131071, -8192);
    add_apply(2);
    add_idle(2, 2);
    add_group(2, 2'b11, pack_group(32767, -32768, 32767, -32768));
    add_group(2, 2'b11, pack_group(20000, -20000, 20000, -20000));
    add_group(2, 2'b11, pack_group(100, -100, 100, -100));
    add_idle(3, 6);
    add_write(3, 0, 49152, 100);
    add_write(3, 1, -16384, -200);
    add_apply(3);
    add_idle(3, 2);
    add_group(3, 2'b11, pack_group(4000, -4000, 4000, -4000));
    add_idle(3, 6);
    add_write(3, 0, 81920, -300);      // Pending only
    add_write(3, 1, 32768, 50);
    add_group(3, 2'b11, pack_group(4000, -4000, 4000, -4000));
    add_idle(3, 6);
    add_apply(3);
    add_idle(3, 2);
    add_group(3, 2'b11, pack_group(4000, -4000, 4000, -4000));
    for (int n = 0; n < 40; n++) begin
      state = lcg_next(state);
      valid = state[31:30];
      for (int k = 0; k < channels * parallel_samples; k++) begin
        state = lcg_next(state);
        data[k*sample_width +: sample_width] = state[31:16];
      end
      add_group(4, valid, data);
    end
  endfunction

  task automatic drive_entry(input entry_t e);
    @(negedge data_clk);
    config_write = 1'b0;
    config_apply = 1'b0;
    in_valid = '0;
    case (e.kind)
      kind_write: begin
        config_write = 1'b1;
        config_channel = channel_index_width'(e.channel);
        config_scale = e.scale;
        config_offset = e.offset;
      end
      kind_apply: config_apply = 1'b1;
      kind_group: begin
        in_data = e.data;
        in_valid = e.valid;
      end
      default: repeat (e.cycles - 1) @(negedge data_clk);
    endcase
  endtask

  // Stream goes idle until every expected group has come out
  task automatic drain(output bit timed_out);
    int waited;
    waited = 0;
    @(negedge data_clk);
    config_write = 1'b0;
    config_apply = 1'b0;
    in_valid = '0;
    while (pending_count != 0 && waited < drain_timeout) begin
      @(negedge data_clk);
      waited++;
    end
    timed_out = (pending_count != 0);
    if (timed_out) begin
      $display("Error at %0t ns: timed out waiting for out_valid", $time);
    end
  endtask

  initial begin : main
    int  first_checks;
    int  first_errors;
    int  test_checks;
    int  test_errors;
    int  tests_passed;
    int  tests_failed;
    bit  timed_out;
    data_reset = 1'b1;
    in_data = '0;
    in_valid = '0;
    config_write = 1'b0;
    config_channel = '0;
    config_scale = '0;
    config_offset = '0;
    config_apply = 1'b0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    build_stimulus();
    repeat (3) @(negedge data_clk);
    data_reset = 1'b0;
    first_checks = check_count;
    first_errors = error_count;
    for (int i = 0; i < stimulus.size() && !timed_out; i++) begin
      drive_entry(stimulus[i]);
      if (i == stimulus.size() - 1 || stimulus[i+1].test != stimulus[i].test) begin
        drain(timed_out);
        test_checks = check_count - first_checks;
        test_errors = error_count - first_errors;
        if (test_errors == 0 && test_checks > 0 && !timed_out) begin
          tests_passed++;
          $display("Test %0d (%s) passed, %0d samples checked",
                   stimulus[i].test + 1, test_names[stimulus[i].test], test_checks);
        end else begin
          tests_failed++;
          $display("Test %0d (%s) failed, %0d errors in %0d samples checked",
                   stimulus[i].test + 1, test_names[stimulus[i].test], test_errors,
                   test_checks);
        end
        first_checks = check_count;
        first_errors = error_count;
      end
    end
    $display("Tests passed: %0d, tests failed: %0d, sample errors: %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && tests_passed == num_tests && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
rtl/affine_pkg.sv
rtl/coefficient_bank.sv
rtl/affine_datapath.sv
rtl/output_saturator.sv
rtl/affine_scaler_top.sv
verification/affine_checker.sv
verification/affine_tb.sv

//--- Bender.yml
package:
  name: affine_scaler

dependencies: {}

sources:
  # Design, package first
  - files:
      - rtl/affine_pkg.sv
      - rtl/coefficient_bank.sv
      - rtl/affine_datapath.sv
      - rtl/output_saturator.sv
      - rtl/affine_scaler_top.sv

  # Testbench, top module affine_tb
  - target: test
    files:
      - verification/affine_checker.sv
      - verification/affine_tb.sv
